//--- logic/flash_pkg.sv
`default_nettype none

package flash_pkg;

    // SPI NOR instruction codes
    typedef enum logic [7:0] {
        OP_RDSR = 8'h05,
        OP_RDID = 8'h9F
    } flash_opcode_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_READ,
        ST_END
    } xfer_state_e;

    parameter int CMD_BITS = 8;
    parameter int ID_BITS  = 24;   // JEDEC manufacturer + device
    parameter int SR_BITS  = 8;

    // Longest frame is 32 rising edges
    parameter int EDGE_W   = 6;

endpackage

`default_nettype wire

//--- logic/sck_timer.sv
`default_nettype none

module sck_timer
    import flash_pkg::*;
#(
    parameter int HALF_CYCLES = 5
) (
    input  logic              sys_clk,
    input  logic              sys_rst_n,
    input  logic              sck_run,
    output logic              spi_sck,
    output logic              shift_stb,
    output logic              sample_stb,
    output logic [EDGE_W-1:0] edge_cnt
);

    localparam int CNT_W = $clog2(HALF_CYCLES);

    logic [CNT_W-1:0] half_cnt;
    logic             half_end;

    assign half_end = (half_cnt == CNT_W'(HALF_CYCLES - 1));

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            half_cnt <= '0;
            spi_sck  <= 1'b0;
            edge_cnt <= '0;
        end else if (!sck_run) begin
            half_cnt <= '0;
            spi_sck  <= 1'b0;
            edge_cnt <= '0;
        end else if (half_end) begin
            half_cnt <= '0;
            spi_sck  <= ~spi_sck;
            if (!spi_sck)
                edge_cnt <= edge_cnt + 1'b1;   // Counting rises only
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    // First low half of the frame, then every falling edge
    assign shift_stb = sck_run &&
                       ((spi_sck && half_end) ||
                        (!spi_sck && half_cnt == '0 && edge_cnt == '0));

    assign sample_stb = sck_run && !spi_sck && half_end;   // SCK rises at this edge

    a_sck_idle_low: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        $rose(spi_sck) |-> $past(sck_run)
    );

endmodule

`default_nettype wire

//--- logic/xfer_fsm.sv
`default_nettype none

module xfer_fsm
    import flash_pkg::*;
(
    input  logic              sys_clk,
    input  logic              sys_rst_n,
    input  logic              start,
    input  logic              cmd_sel,
    input  logic              sample_stb,
    input  logic              shift_stb,
    input  logic [EDGE_W-1:0] edge_cnt,
    output logic              spi_cs_n,
    output logic              busy,
    output logic              done,
    output logic              sck_run,
    output logic              load,
    output logic              capture,
    output flash_opcode_e     opcode
);

    xfer_state_e       state;
    flash_opcode_e     opcode_q;
    flash_opcode_e     next_op;
    logic [EDGE_W-1:0] frame_edges;

    assign next_op = cmd_sel ? OP_RDSR : OP_RDID;

    // Shifter sees the new opcode while idle so load can fill it
    assign opcode = (state == ST_IDLE) ? next_op : opcode_q;

    assign frame_edges = (opcode_q == OP_RDID) ? EDGE_W'(CMD_BITS + ID_BITS)
                                               : EDGE_W'(CMD_BITS + SR_BITS);

    assign busy    = (state != ST_IDLE);
    assign load    = start && (state == ST_IDLE);   // Busy starts are dropped
    assign capture = (state == ST_END) && shift_stb;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= ST_IDLE;
            opcode_q <= OP_RDID;
            spi_cs_n <= 1'b1;
            sck_run  <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state    <= ST_CMD;
                        opcode_q <= next_op;
                        spi_cs_n <= 1'b0;
                        sck_run  <= 1'b1;
                    end
                end
                ST_CMD: begin
                    if (edge_cnt == EDGE_W'(CMD_BITS))
                        state <= ST_READ;
                end
                ST_READ: begin
                    // Last rising edge of the frame
                    if (sample_stb && edge_cnt == frame_edges - 1'b1)
                        state <= ST_END;
                end
                ST_END: begin
                    if (shift_stb) begin   // SCK falls here
                        state    <= ST_IDLE;
                        spi_cs_n <= 1'b1;
                        sck_run  <= 1'b0;
                        done     <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // done only closes a frame that was running
    a_done_after_frame: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        done |-> spi_cs_n && $past(!spi_cs_n)
    );

    a_run_while_busy: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        sck_run |-> busy
    );

endmodule

`default_nettype wire

//--- logic/spi_shifter.sv
`default_nettype none

module spi_shifter
    import flash_pkg::*;
(
    input  logic          sys_clk,
    input  logic          sys_rst_n,
    input  logic          load,
    input  flash_opcode_e opcode,
    input  logic          shift_stb,
    input  logic          sample_stb,
    input  logic          spi_miso,
    output logic          spi_mosi,
    output logic [23:0]   rx_data
);

    // One strobe past the opcode marks the read phase
    localparam logic [3:0] READ_PHASE = 4'(CMD_BITS + 1);

    logic [7:0] tx_byte;
    logic [3:0] tx_cnt;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            tx_cnt   <= '0;
            spi_mosi <= 1'b1;
        end else if (load) begin
            tx_cnt <= '0;
        end else if (shift_stb) begin
            if (tx_cnt < 4'(CMD_BITS)) begin
                spi_mosi <= tx_byte[7];   // MSB first
                tx_cnt   <= tx_cnt + 1'b1;
            end else begin
                spi_mosi <= 1'b1;
                tx_cnt   <= READ_PHASE;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (load)
            tx_byte <= opcode;
        else if (shift_stb)
            tx_byte <= {tx_byte[6:0], 1'b1};
    end

    always_ff @(posedge sys_clk) begin
        if (load)
            rx_data <= '0;
        else if (sample_stb && tx_cnt == READ_PHASE)
            rx_data <= {rx_data[22:0], spi_miso};   // First bit ends at MSB
    end

endmodule

`default_nettype wire

//--- logic/id_result.sv
`default_nettype none

module id_result
    import flash_pkg::*;
#(
    parameter logic [23:0] EXPECTED_ID = 24'h202015
) (
    input  logic          sys_clk,
    input  logic          sys_rst_n,
    input  logic          capture,
    input  flash_opcode_e opcode,
    input  logic [23:0]   rx_data,
    output logic [23:0]   flash_id,
    output logic [7:0]    status,
    output logic          id_valid
);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            flash_id <= '0;
            status   <= '0;
            id_valid <= 1'b0;
        end else begin
            id_valid <= 1'b0;
            if (capture && opcode == OP_RDID) begin
                flash_id <= rx_data;
                id_valid <= (rx_data == EXPECTED_ID);
            end
            if (capture && opcode == OP_RDSR)
                status <= rx_data[SR_BITS-1:0];   // Only 8 bits shifted in
        end
    end

    a_valid_on_capture: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        $rose(id_valid) |-> $past(capture)
    );

endmodule

`default_nettype wire

//--- logic/spi_flash_reader.sv
`default_nettype none

module spi_flash_reader
    import flash_pkg::*;
#(
    parameter int          HALF_CYCLES = 5,
    parameter logic [23:0] EXPECTED_ID = 24'h202015
) (
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        start,
    input  logic        cmd_sel,     // 0 RDID, 1 RDSR
    input  logic        spi_miso,
    output logic        spi_sck,
    output logic        spi_cs_n,
    output logic        spi_mosi,
    output logic        busy,
    output logic        done,
    output logic [23:0] flash_id,
    output logic [7:0]  status,
    output logic        id_valid
);

    logic              sck_run;
    logic              shift_stb;
    logic              sample_stb;
    logic [EDGE_W-1:0] edge_cnt;
    logic              load;
    logic              capture;
    flash_opcode_e     opcode;
    logic [23:0]       rx_data;

    sck_timer #(
        .HALF_CYCLES(HALF_CYCLES)
    ) i_sck_timer (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .sck_run   (sck_run),
        .spi_sck   (spi_sck),
        .shift_stb (shift_stb),
        .sample_stb(sample_stb),
        .edge_cnt  (edge_cnt)
    );

    xfer_fsm i_xfer_fsm (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .start     (start),
        .cmd_sel   (cmd_sel),
        .sample_stb(sample_stb),
        .shift_stb (shift_stb),
        .edge_cnt  (edge_cnt),
        .spi_cs_n  (spi_cs_n),
        .busy      (busy),
        .done      (done),
        .sck_run   (sck_run),
        .load      (load),
        .capture   (capture),
        .opcode    (opcode)
    );

    spi_shifter i_spi_shifter (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .load      (load),
        .opcode    (opcode),
        .shift_stb (shift_stb),
        .sample_stb(sample_stb),
        .spi_miso  (spi_miso),
        .spi_mosi  (spi_mosi),
        .rx_data   (rx_data)
    );

    id_result #(
        .EXPECTED_ID(EXPECTED_ID)
    ) i_id_result (
        .sys_clk  (sys_clk),
        .sys_rst_n(sys_rst_n),
        .capture  (capture),
        .opcode   (opcode),
        .rx_data  (rx_data),
        .flash_id (flash_id),
        .status   (status),
        .id_valid (id_valid)
    );

endmodule

`default_nettype wire

//--- sim/flash_model.sv
`default_nettype none

module flash_model
    import flash_pkg::*;
(
    input  logic        spi_sck,
    input  logic        spi_cs_n,
    input  logic        spi_mosi,
    input  logic [23:0] id_value,
    input  logic [7:0]  status_value,
    output logic        spi_miso,
    output logic [7:0]  rx_opcode,
    output int          rise_cnt,
    output int          frame_cnt
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  cmd_shift;
    logic [23:0] tx_shift;
    int          bit_cnt;

    initial begin
        spi_miso  = 1'b1;
        rx_opcode = '0;
        rise_cnt  = 0;
        frame_cnt = 0;
        bit_cnt   = 0;
    end

    always @(negedge spi_cs_n) begin
        frame_cnt = frame_cnt + 1;
        rise_cnt  = 0;
        bit_cnt   = 0;
        cmd_shift = '0;
        tx_shift  = '1;
    end

    always @(posedge spi_cs_n)
        spi_miso = 1'b1;   // Bus released

    // Opcode enters MSB first on rising SCK
    always @(posedge spi_sck) begin
        if (!spi_cs_n) begin
            rise_cnt = rise_cnt + 1;
            if (bit_cnt < CMD_BITS) begin
                cmd_shift = {cmd_shift[6:0], spi_mosi};
                if (bit_cnt == CMD_BITS - 1) begin
                    rx_opcode = cmd_shift;
                    case (cmd_shift)
                        OP_RDID: tx_shift = id_value;
                        OP_RDSR: tx_shift = {status_value, 16'hFFFF};
                        default: tx_shift = '1;
                    endcase
                end
            end
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge spi_sck) begin
        if (!spi_cs_n && bit_cnt >= CMD_BITS) begin
            spi_miso = tx_shift[23];   // Response MSB first
            tx_shift = {tx_shift[22:0], 1'b1};
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_spi_flash_reader.sv
`default_nettype none

module tb_spi_flash_reader
    import flash_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          HALF        = 3;
    localparam logic [23:0] GOOD_ID     = 24'h202015;
    localparam int          NUM_TXN     = 40;
    localparam int          MAX_GAP     = 16;
    localparam int          CLK_PERIOD  = 4;
    localparam int          LONG_FRAME  = 1 + (CMD_BITS + ID_BITS) * 2 * HALF;
    localparam int          TIMEOUT_CYC = NUM_TXN * (LONG_FRAME + MAX_GAP + 2) + 200;

    logic        sys_clk;
    logic        sys_rst_n;
    logic        start;
    logic        cmd_sel;
    logic        spi_miso;
    logic        spi_sck;
    logic        spi_cs_n;
    logic        spi_mosi;
    logic        busy;
    logic        done;
    logic [23:0] flash_id;
    logic [7:0]  status;
    logic        id_valid;
    logic [23:0] id_value;
    logic [7:0]  status_value;
    logic [7:0]  rx_opcode;
    int          rise_cnt;
    int          frame_cnt;
    int          done_cnt;
    logic        prev_cs_n;
    logic [23:0] exp_flash_id;
    logic [7:0]  exp_status;
    string       test_name;

    spi_flash_reader #(
        .HALF_CYCLES(HALF),
        .EXPECTED_ID(GOOD_ID)
    ) i_spi_flash_reader (
        .sys_clk  (sys_clk),
        .sys_rst_n(sys_rst_n),
        .start    (start),
        .cmd_sel  (cmd_sel),
        .spi_miso (spi_miso),
        .spi_sck  (spi_sck),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .busy     (busy),
        .done     (done),
        .flash_id (flash_id),
        .status   (status),
        .id_valid (id_valid)
    );

    flash_model i_flash_model (
        .spi_sck     (spi_sck),
        .spi_cs_n    (spi_cs_n),
        .spi_mosi    (spi_mosi),
        .id_value    (id_value),
        .status_value(status_value),
        .spi_miso    (spi_miso),
        .rx_opcode   (rx_opcode),
        .rise_cnt    (rise_cnt),
        .frame_cnt   (frame_cnt)
    );

    initial sys_clk = 1'b0;
    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected,
                     actual);
            stop_on_error();
        end
    endtask

    // Frame shape and pulse alignment checked between clock edges
    always @(negedge sys_clk) begin
        if (sys_rst_n) begin
            if (spi_cs_n !== prev_cs_n)
                check_value("sck_at_cs_edge", 0, spi_sck);
            if (id_valid)
                check_value("id_valid_with_done", 1, done);
            if (done)
                done_cnt = done_cnt + 1;
        end
        prev_cs_n = spi_cs_n;
    end

    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run hung", TIMEOUT_CYC);
        stop_on_error();
    end

    initial begin
        int   gap;
        int   cycles;
        int   extra_at;
        int   frame_bits;
        logic sel;
        void'($urandom(59));
        sys_rst_n    = 1'b0;
        start        = 1'b0;
        cmd_sel      = 1'b0;
        id_value     = '0;
        status_value = '0;
        exp_flash_id = '0;
        exp_status   = '0;
        done_cnt     = 0;
        prev_cs_n    = 1'b1;
        test_name    = "reset";
        repeat (4) @(negedge sys_clk);
        sys_rst_n = 1'b1;
        @(negedge sys_clk);
        check_value("spi_cs_n", 1, spi_cs_n);
        check_value("spi_sck", 0, spi_sck);
        check_value("spi_mosi", 1, spi_mosi);
        check_value("busy", 0, busy);
        check_value("done", 0, done);
        check_value("id_valid", 0, id_valid);
        check_value("flash_id", 0, flash_id);
        check_value("status", 0, status);

        for (int n = 0; n < NUM_TXN; n++) begin
            gap = $urandom_range(MAX_GAP);
            repeat (gap) @(negedge sys_clk);
            sel          = 1'($urandom_range(1));
            id_value     = ($urandom_range(1) == 1) ? GOOD_ID : 24'($urandom);
            status_value = 8'($urandom);
            extra_at     = $urandom_range(60, 2);   // Inside even the short frame
            frame_bits   = CMD_BITS + (sel ? SR_BITS : ID_BITS);
            test_name    = $sformatf("%s_%0d", sel ? "rdsr" : "rdid", n);
            if (sel)
                exp_status = status_value;
            else
                exp_flash_id = id_value;

            start   = 1'b1;
            cmd_sel = sel;
            cycles  = 0;
            while (!done) begin
                @(negedge sys_clk);
                cycles  = cycles + 1;
                start   = (cycles == extra_at);
                cmd_sel = 1'($urandom);
                if (cycles == 1)
                    check_value("busy_after_start", 1, busy);
            end

            check_value("latency", 1 + frame_bits * 2 * HALF, cycles);
            check_value("opcode", sel ? OP_RDSR : OP_RDID, rx_opcode);
            check_value("sck_rises", frame_bits, rise_cnt);
            check_value("flash_id", exp_flash_id, flash_id);
            check_value("status", exp_status, status);
            check_value("id_valid", !sel && id_value == GOOD_ID, id_valid);
            check_value("cs_n_at_done", 1, spi_cs_n);
            check_value("busy_at_done", 0, busy);
            @(negedge sys_clk);
            check_value("done_width", 0, done);
            check_value("frame_count", n + 1, frame_cnt);
            check_value("done_count", n + 1, done_cnt);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
logic/flash_pkg.sv
logic/sck_timer.sv
logic/xfer_fsm.sv
logic/spi_shifter.sv
logic/id_result.sv
logic/spi_flash_reader.sv
sim/flash_model.sv
sim/tb_spi_flash_reader.sv
